//--- design/cia_pkg.sv
// CIA shared definitions
// Register map, registered bus access, timer control and event records,
// and the two views of the interrupt control register
package cia_pkg;

  localparam logic [3:0] REG_PRA   = 4'd0;
  localparam logic [3:0] REG_PRB   = 4'd1;
  localparam logic [3:0] REG_DDRA  = 4'd2;
  localparam logic [3:0] REG_DDRB  = 4'd3;
  localparam logic [3:0] REG_TA_LO = 4'd4;
  localparam logic [3:0] REG_TA_HI = 4'd5;
  localparam logic [3:0] REG_TB_LO = 4'd6;
  localparam logic [3:0] REG_TB_HI = 4'd7;
  localparam logic [3:0] REG_ICR   = 4'd13;
  localparam logic [3:0] REG_CRA   = 4'd14;
  localparam logic [3:0] REG_CRB   = 4'd15;

  typedef struct packed {
    logic [15:0] sel;
    logic [7:0]  data;
  } reg_access_t;

  typedef struct packed {
    logic bit7;
    logic chain;       // timer B only
    logic bit5;
    logic force_load;
    logic one_shot;
    logic out_toggle;
    logic pb_on;
    logic start;
  } timer_ctrl_t;

  typedef struct packed {
    logic        underflow;
    logic        pb_level;
    logic [15:0] count;
  } timer_evt_t;

  typedef struct packed {
    logic       set_clr;
    logic [1:0] rsvd;
    logic [4:0] mask;
  } icr_wr_t;

  typedef struct packed {
    logic       irq;
    logic [1:0] rsvd;
    logic [4:0] flags;
  } icr_rd_t;

  typedef union packed {
    icr_wr_t wr;
    icr_rd_t rd;
  } icr_word_u;

endpackage

//--- design/cia_bus_decode.sv
// CIA bus decode
// Turns the raw host bus into registered one-hot write and read strobes
// and returns the addressed register byte on db_out
module cia_bus_decode import cia_pkg::*; (
  input  logic             clk,
  input  logic             int_reset,
  input  logic             cs,
  input  logic             rw,
  input  logic [3:0]       rs,
  input  logic [7:0]       db_in,
  input  logic [15:0][7:0] rd_bytes,
  output reg_access_t      wr_acc,
  output reg_access_t      rd_acc,
  output logic [7:0]       db_out
);

  logic [15:0] addr_hot;
  logic [7:0]  rd_mux;

  assign addr_hot = 16'd1 << rs;

  // Strobes live for exactly one cycle
  always_ff @(posedge clk) begin
    if (int_reset) begin
      wr_acc.sel <= '0;
      rd_acc.sel <= '0;
    end else begin
      wr_acc.sel <= (cs && !rw) ? addr_hot : '0;
      rd_acc.sel <= (cs && rw) ? addr_hot : '0;
    end
  end

  always_ff @(posedge clk) begin
    wr_acc.data <= db_in;
    rd_acc.data <= 8'h00;
  end

  // AND-OR select of the one addressed byte
  always_comb begin
    rd_mux = 8'h00;
    for (int i = 0; i < 16; i++) begin
      rd_mux = rd_mux | (rd_bytes[i] & {8{rd_acc.sel[i]}});
    end
  end

  // Holds until the next read
  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= 8'h00;
    end else if (|rd_acc.sel) begin
      db_out <= rd_mux;
    end
  end

endmodule

//--- design/cia_port.sv
// CIA I/O port
// Data and direction registers for one 8-bit port; undriven pins float
// high, and bits 6 and 7 can be taken over by timer outputs
module cia_port import cia_pkg::*; (
  input  logic        clk,
  input  logic        int_reset,
  input  reg_access_t wr_acc,
  input  logic        sel_data,
  input  logic        sel_ddr,
  input  logic [7:0]  pin_in,
  input  logic        pb6_level,
  input  logic        pb7_level,
  input  logic [1:0]  pb_overlay,
  output logic [7:0]  pin_out,
  output logic [7:0]  rd_data,
  output logic [7:0]  rd_ddr
);

  logic [7:0] pr;
  logic [7:0] ddr;
  logic [7:0] drive;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pr  <= 8'h00;
      ddr <= 8'h00;
    end else begin
      if (sel_data) pr <= wr_acc.data;
      if (sel_ddr) ddr <= wr_acc.data;
    end
  end

  assign drive = pr | ~ddr;

  always_comb begin
    pin_out = drive;
    // Timer overlays
    if (pb_overlay[0]) pin_out[6] = pb6_level;
    if (pb_overlay[1]) pin_out[7] = pb7_level;
  end

  // Data reads sample the pins
  assign rd_data = pin_in;
  assign rd_ddr  = ddr;

endmodule

//--- design/cia_timer.sv
// CIA interval timer
// 16-bit down counter with reload latch, one-shot and continuous modes,
// force load, chaining and a PB output that pulses or toggles on underflow
module cia_timer import cia_pkg::*; (
  input  logic        clk,
  input  logic        int_reset,
  input  logic        phi2_p,
  input  logic        chain_in,
  input  logic        sel_lo,
  input  logic        sel_hi,
  input  logic        sel_ctrl,
  input  logic [7:0]  wr_data,
  output timer_evt_t  evt,
  output timer_ctrl_t ctrl
);

  timer_ctrl_t ctrl_q;
  timer_ctrl_t ctrl_wr;
  logic [15:0] latch;
  logic [15:0] count;
  logic        count_en;
  logic        hit_zero;
  logic        uf_q;
  logic        toggle_ff;

  assign ctrl_wr  = timer_ctrl_t'(wr_data);
  assign count_en = ctrl_q.start && (ctrl_q.chain ? chain_in : phi2_p);
  // At zero the next count pulse underflows
  assign hit_zero = count_en && (count == 16'h0000);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      ctrl_q    <= '0;
      latch     <= 16'hffff;
      count     <= 16'hffff;
      uf_q      <= 1'b0;
      toggle_ff <= 1'b0;
    end else begin
      uf_q <= hit_zero;

      if (hit_zero) begin
        count     <= latch;
        toggle_ff <= ~toggle_ff;
        if (ctrl_q.one_shot) ctrl_q.start <= 1'b0;
      end else if (count_en) begin
        count <= count - 16'd1;
      end

      if (sel_lo) begin
        latch[7:0] <= wr_data;
      end

      if (sel_hi) begin
        latch[15:8] <= wr_data;
        // Stopped timer loads straight away
        if (!ctrl_q.start) count <= {wr_data, latch[7:0]};
      end

      if (sel_ctrl) begin
        ctrl_q            <= ctrl_wr;
        ctrl_q.force_load <= 1'b0;
        if (ctrl_wr.force_load) count <= latch;
        if (ctrl_wr.start && !ctrl_q.start) toggle_ff <= 1'b1;
      end
    end
  end

  always_comb begin
    evt.underflow = uf_q;
    evt.pb_level  = ctrl_q.out_toggle ? toggle_ff : uf_q;
    evt.count     = count;
  end

  assign ctrl = ctrl_q;

endmodule

//--- design/cia_irq.sv
// CIA interrupt control
// Sticky timer flags, mask set and clear, clear on read and the
// active-low interrupt line
module cia_irq import cia_pkg::*; (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       ta_underflow,
  input  logic       tb_underflow,
  input  logic       wr_icr,
  input  logic       rd_icr,
  input  logic [7:0] wr_data,
  output logic [7:0] status,
  output logic       irq_n
);

  icr_word_u  wr_word;
  icr_word_u  rd_word;
  logic [1:0] flags;
  logic [1:0] mask;
  logic [1:0] events;

  assign wr_word = icr_word_u'(wr_data);
  assign events  = {tb_underflow, ta_underflow};

  // Only the two timer sources exist
  always_ff @(posedge clk) begin
    if (int_reset) begin
      mask <= 2'b00;
    end else if (wr_icr) begin
      if (wr_word.wr.set_clr) mask <= mask | wr_word.wr.mask[1:0];
      else mask <= mask & ~wr_word.wr.mask[1:0];
    end
  end

  // A read clears old flags but keeps events from the same cycle
  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags <= 2'b00;
      irq_n <= 1'b1;
    end else begin
      flags <= rd_icr ? events : (flags | events);
      irq_n <= rd_icr | ~|(flags & mask);
    end
  end

  always_comb begin
    rd_word.rd.irq   = ~irq_n;
    rd_word.rd.rsvd  = 2'b00;
    rd_word.rd.flags = {3'b000, flags};
  end

  assign status = rd_word;

endmodule

//--- design/cia_top.sv
// CIA peripheral adapter top level
// Bus decode, two I/O ports, two interval timers and interrupt control
module cia_top import cia_pkg::*; (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2_p,
  input  logic       cs,
  input  logic       rw,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  output logic [7:0] db_out,
  input  logic [7:0] pa_in,
  output logic [7:0] pa_out,
  input  logic [7:0] pb_in,
  output logic [7:0] pb_out,
  output logic       irq_n
);

  reg_access_t      wr_acc;
  reg_access_t      rd_acc;
  logic [15:0][7:0] rd_bytes;
  timer_evt_t       ta_evt;
  timer_evt_t       tb_evt;
  timer_ctrl_t      ta_ctrl;
  timer_ctrl_t      tb_ctrl;

  cia_bus_decode u_decode (
    .clk(clk), .int_reset(int_reset), .cs(cs), .rw(rw), .rs(rs), .db_in(db_in),
    .rd_bytes(rd_bytes), .wr_acc(wr_acc), .rd_acc(rd_acc), .db_out(db_out)
  );

  cia_port port_a (
    .clk(clk), .int_reset(int_reset), .wr_acc(wr_acc),
    .sel_data(wr_acc.sel[REG_PRA]), .sel_ddr(wr_acc.sel[REG_DDRA]),
    .pin_in(pa_in), .pb6_level(1'b0), .pb7_level(1'b0), .pb_overlay(2'b00),
    .pin_out(pa_out), .rd_data(rd_bytes[REG_PRA]), .rd_ddr(rd_bytes[REG_DDRA])
  );

  cia_port port_b (
    .clk(clk), .int_reset(int_reset), .wr_acc(wr_acc),
    .sel_data(wr_acc.sel[REG_PRB]), .sel_ddr(wr_acc.sel[REG_DDRB]),
    .pin_in(pb_in), .pb6_level(ta_evt.pb_level), .pb7_level(tb_evt.pb_level),
    .pb_overlay({tb_ctrl.pb_on, ta_ctrl.pb_on}),
    .pin_out(pb_out), .rd_data(rd_bytes[REG_PRB]), .rd_ddr(rd_bytes[REG_DDRB])
  );

  // Chain source equals phi2_p, so the chain bit has no effect on timer A
  cia_timer timer_a (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .chain_in(phi2_p),
    .sel_lo(wr_acc.sel[REG_TA_LO]), .sel_hi(wr_acc.sel[REG_TA_HI]),
    .sel_ctrl(wr_acc.sel[REG_CRA]), .wr_data(wr_acc.data),
    .evt(ta_evt), .ctrl(ta_ctrl)
  );

  cia_timer timer_b (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .chain_in(ta_evt.underflow),
    .sel_lo(wr_acc.sel[REG_TB_LO]), .sel_hi(wr_acc.sel[REG_TB_HI]),
    .sel_ctrl(wr_acc.sel[REG_CRB]), .wr_data(wr_acc.data),
    .evt(tb_evt), .ctrl(tb_ctrl)
  );

  cia_irq u_irq (
    .clk(clk), .int_reset(int_reset),
    .ta_underflow(ta_evt.underflow), .tb_underflow(tb_evt.underflow),
    .wr_icr(wr_acc.sel[REG_ICR]), .rd_icr(rd_acc.sel[REG_ICR]),
    .wr_data(wr_acc.data), .status(rd_bytes[REG_ICR]), .irq_n(irq_n)
  );

  assign rd_bytes[REG_TA_LO] = ta_evt.count[7:0];
  assign rd_bytes[REG_TA_HI] = ta_evt.count[15:8];
  assign rd_bytes[REG_TB_LO] = tb_evt.count[7:0];
  assign rd_bytes[REG_TB_HI] = tb_evt.count[15:8];
  assign rd_bytes[REG_CRA]   = ta_ctrl;
  assign rd_bytes[REG_CRB]   = tb_ctrl;

  // TOD and serial addresses read as zero
  assign rd_bytes[8]  = 8'h00;
  assign rd_bytes[9]  = 8'h00;
  assign rd_bytes[10] = 8'h00;
  assign rd_bytes[11] = 8'h00;
  assign rd_bytes[12] = 8'h00;

endmodule

//--- tests/cia_assert.sv
// CIA bound checks
// Interrupt line source, read data hold and underflow pulse width
module cia_assert (
  input logic       clk,
  input logic       int_reset,
  input logic       irq_n,
  input logic       masked_pending,
  input logic       rd_any,
  input logic [7:0] db_out,
  input logic       ta_underflow,
  input logic       tb_underflow
);

  int fails = 0;

  // irq_n follows the masked flags one cycle late
  irq_has_source: assert property (@(posedge clk) disable iff (int_reset)
    !irq_n |-> $past(masked_pending))
    else begin
      fails++;
      $error("irq_n low with no masked flag set");
    end

  db_out_hold: assert property (@(posedge clk) disable iff (int_reset)
    $changed(db_out) |-> $past(rd_any))
    else begin
      fails++;
      $error("db_out changed without a read");
    end

  ta_pulse_width: assert property (@(posedge clk) disable iff (int_reset)
    ta_underflow |=> !ta_underflow)
    else begin
      fails++;
      $error("timer A underflow longer than one cycle");
    end

  tb_pulse_width: assert property (@(posedge clk) disable iff (int_reset)
    tb_underflow |=> !tb_underflow)
    else begin
      fails++;
      $error("timer B underflow longer than one cycle");
    end

endmodule

bind cia_top cia_assert u_assert (
  .clk(clk),
  .int_reset(int_reset),
  .irq_n(irq_n),
  .masked_pending(|(u_irq.flags & u_irq.mask)),
  .rd_any(|rd_acc.sel),
  .db_out(db_out),
  .ta_underflow(ta_evt.underflow),
  .tb_underflow(tb_evt.underflow)
);

//--- tests/cia_tb.sv
// CIA testbench
// Replays the operation list from the stimulus file on the DUT and
// checks read data, port pins and irq_n
module cia_tb;

  logic       clk;
  logic       int_reset;
  logic       phi2_p;
  logic       cs;
  logic       rw;
  logic [3:0] rs;
  logic [7:0] db_in;
  logic [7:0] db_out;
  logic [7:0] pa_in;
  logic [7:0] pa_out;
  logic [7:0] pb_in;
  logic [7:0] pb_out;
  logic       irq_n;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int total  = 0;
  int limit  = 0;

  cia_top DUT (.*);

  always #20 clk = ~clk;

  // Watchdog on the number of clock cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not end within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic int op_cycles(string op, logic [7:0] arg);
    if (op == "P") return 2 * arg + 2;
    return (op == "W" || op == "R") ? 2 : 0;
  endfunction

  task automatic check_byte(string name, logic [7:0] expected, logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One bus cycle, then one idle cycle for the registered strobe
  task automatic bus_access(logic read, logic [3:0] addr, logic [7:0] data);
    cs    = 1'b1;
    rw    = read;
    rs    = addr;
    db_in = data;
    @(negedge clk);
    cs = 1'b0;
    rw = 1'b1;
    @(negedge clk);
  endtask

  task automatic run_op(string name, string op, logic [7:0] arg, logic [7:0] data);
    if (op == "W") begin
      bus_access(1'b0, arg[3:0], data);
    end else if (op == "R") begin
      bus_access(1'b1, arg[3:0], 8'h00);
      check_byte(name, data, db_out);
    end else if (op == "P") begin
      repeat (arg) begin
        phi2_p = 1'b1;
        @(negedge clk);
        phi2_p = 1'b0;
        @(negedge clk);
      end
      // Time for underflows to reach the flags and irq_n
      repeat (2) @(negedge clk);
    end else if (op == "I") begin
      check_byte(name, data, {7'd0, irq_n});
    end else if (op == "A") begin
      check_byte(name, data, pa_out);
    end else if (op == "B") begin
      check_byte(name, data, pb_out);
    end else begin
      errors++;
      $display("Unknown operation %s in test %s", op, name);
    end
  endtask

  // Walks the stimulus file, either sizing the run or executing it
  task automatic replay(bit execute);
    int         fd;
    int         n;
    string      line;
    string      name;
    string      op;
    logic [7:0] arg;
    logic [7:0] data;

    fd = $fopen("tests/cia_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %s %h %h", name, op, arg, data);
      if (n == 4 && line.getc(0) != "#") begin
        if (execute) run_op(name, op, arg, data);
        else total += op_cycles(op, arg);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk       = 1'b0;
    int_reset = 1'b1;
    phi2_p    = 1'b0;
    cs        = 1'b0;
    rw        = 1'b1;
    rs        = 4'h0;
    db_in     = 8'h00;
    // Fixed pin levels seen by data register reads
    pa_in     = 8'h5a;
    pb_in     = 8'h3c;
    replay(1'b0);
    limit = 2 * total + 100;
    repeat (10) @(negedge clk);
    int_reset = 1'b0;
    check_byte("reset_db_out", 8'h00, db_out);
    check_byte("reset_irq_n", 8'h01, {7'd0, irq_n});
    check_byte("reset_pa_out", 8'hff, pa_out);
    check_byte("reset_pb_out", 8'hff, pb_out);
    replay(1'b1);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_assert.fails);
    if (errors == 0 && DUT.u_assert.fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- tests/cia_input.txt
# name op addr/count data/expected, numbers in hex
# op: W write, R read db_out, P phi2_p pulses, I irq_n, A pa_out, B pb_out
port_ddra   W 02 0f
port_pra    W 00 05
port_pa_out A 00 f5
port_pa_rd  R 00 5a
os_lat_lo   W 04 03
os_lat_hi   W 05 00
os_start    W 0e 09
os_run      P 04 00
os_cra      R 0e 08
os_cnt_lo   R 04 03
os_icr      R 0d 01
ct_start    W 0e 07
ct_run1     P 04 00
ct_pb6_lo   B 00 bf
ct_run2     P 06 00
ct_pb6_hi   B 00 ff
ct_cnt      R 04 01
ch_force    W 0e 10
ch_tb_lo    W 06 01
ch_tb_hi    W 07 00
ch_mask     W 0d 82
ch_crb      W 0f 41
ch_cra      W 0e 01
ch_run1     P 07 00
ch_irq_hi   I 00 01
ch_run2     P 01 00
ch_irq_lo   I 00 00
ch_icr      R 0d 83
ch_irq_rel  I 00 01
ch_icr2     R 0d 00
mk_clr_b    W 0d 02
mk_set_a    W 0d 81
mk_start    W 0e 09
mk_run      P 04 00
mk_irq_lo   I 00 00
mk_icr      R 0d 81
st_lat_lo   W 04 34
st_lat_hi   W 05 12
st_cnt_hi   R 05 12
st_new_lo   W 04 78
st_force    W 0e 10
st_fl_lo    R 04 78

//--- filelist.f
design/cia_pkg.sv
design/cia_bus_decode.sv
design/cia_port.sv
design/cia_timer.sv
design/cia_irq.sv
design/cia_top.sv
tests/cia_assert.sv
tests/cia_tb.sv
